// File: src/mipsPkg.sv
`default_nettype none

package mipsPkg;

    typedef logic [31:0] word_t;  // Data word and byte address
    typedef logic [4:0]  regAddr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [3:0]  aluOp_t;

    typedef enum logic [1:0] {
        MulIdle,
        MulRun,
        MulDone
    } mulState_t;

    localparam int NUM_REGS  = 32;
    localparam int MUL_STEPS = 32;  // One step per multiplier bit
    localparam int MUL_CNT_W = $clog2(MUL_STEPS);

    //////////////////////////////////////////////////////////////////////
    localparam opcode_t OP_RTYPE = 6'b000000;
    localparam opcode_t OP_ADDI  = 6'b001000;
    localparam opcode_t OP_ORI   = 6'b001101;
    localparam opcode_t OP_LW    = 6'b100011;
    localparam opcode_t OP_SW    = 6'b101011;
    localparam opcode_t OP_BEQ   = 6'b000100;
    localparam opcode_t OP_J     = 6'b000010;

    localparam funct_t FN_ADD  = 6'b100000;
    localparam funct_t FN_SUB  = 6'b100010;
    localparam funct_t FN_AND  = 6'b100100;
    localparam funct_t FN_OR   = 6'b100101;
    localparam funct_t FN_SLT  = 6'b101010;
    localparam funct_t FN_SLL  = 6'b000000;  // Also the all-zero nop
    localparam funct_t FN_MULT = 6'b011000;
    localparam funct_t FN_MFHI = 6'b010000;
    localparam funct_t FN_MFLO = 6'b010010;

    //////////////////////////////////////////////////////////////////////
    localparam aluOp_t ALU_ADD  = 4'd0;
    localparam aluOp_t ALU_SUB  = 4'd1;
    localparam aluOp_t ALU_AND  = 4'd2;
    localparam aluOp_t ALU_OR   = 4'd3;
    localparam aluOp_t ALU_SLT  = 4'd4;
    localparam aluOp_t ALU_SLL  = 4'd5;
    localparam aluOp_t ALU_MULT = 4'd6;

    localparam logic [1:0] FWD_REG = 2'b00;  // Register file value
    localparam logic [1:0] FWD_WB  = 2'b01;
    localparam logic [1:0] FWD_MEM = 2'b10;

endpackage

`default_nettype wire

// File: src/regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile import mipsPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     we,
    input  regAddr_t ra1,
    input  regAddr_t ra2,
    input  regAddr_t wa,
    input  word_t    wd,
    output word_t    rd1,
    output word_t    rd2
);

    word_t regs [NUM_REGS];

    // Falling edge write lets decode read the writeback value same cycle
    always_ff @(negedge clk) begin
        if (we && !rst && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];  // $zero reads as 0
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

// File: src/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu import mipsPkg::*; (
    input  aluOp_t     aluOp,
    input  word_t      srcA,
    input  word_t      srcB,
    input  logic [4:0] shamt,
    output word_t      result
);

    always_comb begin
        case (aluOp)
            ALU_ADD: result = srcA + srcB;
            ALU_SUB: result = srcA - srcB;
            ALU_AND: result = srcA & srcB;
            ALU_OR:  result = srcA | srcB;
            ALU_SLT: result = {31'b0, $signed(srcA) < $signed(srcB)};
            ALU_SLL: result = srcB << shamt;  // rt shifted by shamt
            default: result = '0;  // mult result comes from the multiplier
        endcase
    end

endmodule

`default_nettype wire

// File: src/multiplyUnit.sv
`timescale 1ns/1ns
`default_nettype none

module multiplyUnit import mipsPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  word_t       srcA,
    input  word_t       srcB,
    output logic [63:0] product,
    output logic        ready
);

    mulState_t              state;
    logic [MUL_CNT_W-1:0]   stepCnt;
    logic                   lastStep;
    logic [63:0]            acc, mcand;
    word_t                  mplier;

    assign lastStep = (stepCnt == (MUL_CNT_W)'(MUL_STEPS - 1));
    assign product  = acc;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= MulIdle;
            stepCnt <= '0;
            ready   <= 1'b0;
        end else begin
            ready <= 1'b0;
            case (state)
                MulIdle: begin
                    if (start) begin
                        state   <= MulRun;
                        stepCnt <= '0;
                    end
                end
                MulRun: begin
                    stepCnt <= stepCnt + 1'b1;
                    if (lastStep) begin
                        state <= MulDone;
                        ready <= 1'b1;  // Held through the MulDone cycle
                    end
                end
                MulDone: state <= MulIdle;
                default: state <= MulIdle;
            endcase
        end
    end

    // Multiplicand sign-extended, multiplier consumed LSB first
    always_ff @(posedge clk) begin
        if (state == MulIdle && start) begin
            acc    <= '0;
            mcand  <= {{32{srcA[31]}}, srcA};
            mplier <= srcB;
        end else if (state == MulRun) begin
            if (mplier[0]) begin
                acc <= lastStep ? acc - mcand : acc + mcand;  // Bit 31 weighs -2^31
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assert property (@(posedge clk) disable iff (rst) ready |-> state == MulDone);

endmodule

`default_nettype wire

// File: src/controller.sv
`timescale 1ns/1ns
`default_nettype none

module controller import mipsPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  opcode_t op,
    input  funct_t  funct,
    input  logic    stallE,
    input  logic    flushE,
    output logic    branchD,
    output logic    jumpD,
    output aluOp_t  aluOpE,
    output logic    aluSrcE,
    output logic    regDstE,
    output logic    hiloWriteE,
    output logic    hiloToRegE,
    output logic    mulStartE,
    output logic    regWriteE,
    output logic    memToRegE,
    output logic    regWriteM,
    output logic    memToRegM,
    output logic    memWriteM,
    output logic    retSrcM,
    output logic    regWriteW,
    output logic    memToRegW
);

    logic   regWriteD, memToRegD, memWriteD, retSrcD;
    logic   aluSrcD, regDstD, multD, hiloToRegD;
    aluOp_t aluOpD;
    logic   memWriteE, retSrcE, multE;

    logic [11:0] ctrlD, ctrlE;

    always_comb begin
        regWriteD  = 1'b0;
        memToRegD  = 1'b0;
        memWriteD  = 1'b0;
        retSrcD    = 1'b0;
        aluSrcD    = 1'b0;
        regDstD    = 1'b0;
        multD      = 1'b0;
        hiloToRegD = 1'b0;
        branchD    = 1'b0;
        jumpD      = 1'b0;
        aluOpD     = ALU_ADD;  // Address add for lw, sw and addi
        case (op)
            OP_RTYPE: begin
                regWriteD = 1'b1;
                regDstD   = 1'b1;
                case (funct)
                    FN_ADD:  aluOpD = ALU_ADD;
                    FN_SUB:  aluOpD = ALU_SUB;
                    FN_AND:  aluOpD = ALU_AND;
                    FN_OR:   aluOpD = ALU_OR;
                    FN_SLT:  aluOpD = ALU_SLT;
                    FN_SLL:  aluOpD = ALU_SLL;
                    FN_MULT: begin
                        regWriteD = 1'b0;
                        multD     = 1'b1;
                        aluOpD    = ALU_MULT;
                    end
                    FN_MFHI: begin
                        retSrcD    = 1'b1;
                        hiloToRegD = 1'b1;  // Pick HI
                    end
                    FN_MFLO: retSrcD = 1'b1;
                    default: regWriteD = 1'b0;  // Unknown funct acts as nop
                endcase
            end
            OP_ADDI: begin
                regWriteD = 1'b1;
                aluSrcD   = 1'b1;
            end
            OP_ORI: begin
                regWriteD = 1'b1;
                aluSrcD   = 1'b1;
                aluOpD    = ALU_OR;
            end
            OP_LW: begin
                regWriteD = 1'b1;
                memToRegD = 1'b1;
                aluSrcD   = 1'b1;
            end
            OP_SW: begin
                memWriteD = 1'b1;
                aluSrcD   = 1'b1;
            end
            OP_BEQ: begin
                branchD = 1'b1;
                aluOpD  = ALU_SUB;
            end
            OP_J:    jumpD = 1'b1;
            default: ;
        endcase
    end

    assign ctrlD = {regWriteD, memToRegD, memWriteD, retSrcD, aluOpD,
                    aluSrcD, regDstD, multD, hiloToRegD};

    // ID/EX keeps step with the datapath's ID/EX register
    always_ff @(posedge clk) begin
        if (rst || (flushE && !stallE)) begin
            ctrlE <= '0;
        end else if (!stallE) begin
            ctrlE <= ctrlD;
        end
    end

    assign {regWriteE, memToRegE, memWriteE, retSrcE, aluOpE,
            aluSrcE, regDstE, multE, hiloToRegE} = ctrlE;
    assign mulStartE  = multE;
    assign hiloWriteE = multE;  // HI/LO written only by mult

    always_ff @(posedge clk) begin
        if (rst) begin
            {regWriteM, memToRegM, memWriteM, retSrcM} <= '0;
            {regWriteW, memToRegW}                     <= '0;
        end else begin
            {regWriteM, memToRegM, memWriteM, retSrcM} <=
                {regWriteE, memToRegE, memWriteE, retSrcE};
            {regWriteW, memToRegW} <= {regWriteM, memToRegM};
        end
    end

endmodule

`default_nettype wire

// File: src/hazardUnit.sv
`timescale 1ns/1ns
`default_nettype none

module hazardUnit import mipsPkg::*; (
    input  logic       clk,
    input  regAddr_t   rsD,
    input  regAddr_t   rtD,
    input  regAddr_t   rsE,
    input  regAddr_t   rtE,
    input  regAddr_t   writeRegE,
    input  regAddr_t   writeRegM,
    input  regAddr_t   writeRegW,
    input  logic       branchD,
    input  logic       jumpD,
    input  logic       pcSrcD,
    input  logic       regWriteE,
    input  logic       memToRegE,
    input  logic       regWriteM,
    input  logic       memToRegM,
    input  logic       regWriteW,
    input  logic       mulStartE,
    input  logic       mulReadyE,
    output logic       stallF,
    output logic       stallD,
    output logic       stallE,
    output logic       flushD,
    output logic       flushE,
    output logic       forwardAD,
    output logic       forwardBD,
    output logic [1:0] forwardAE,
    output logic [1:0] forwardBE
);

    logic lwStall, branchStall, mulStall;
    logic hitE, hitM;

    function automatic logic [1:0] fwdSel(input regAddr_t src);
        if (src != '0 && regWriteM && src == writeRegM) begin
            return FWD_MEM;  // Newest value wins
        end else if (src != '0 && regWriteW && src == writeRegW) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    always_comb begin
        forwardAE = fwdSel(rsE);
        forwardBE = fwdSel(rtE);
    end

    // Writeback needs no branch path since the register file writes early
    assign forwardAD = (rsD != '0) && regWriteM && (rsD == writeRegM);
    assign forwardBD = (rtD != '0) && regWriteM && (rtD == writeRegM);

    assign hitE = (writeRegE != '0) && (writeRegE == rsD || writeRegE == rtD);
    assign hitM = (writeRegM != '0) && (writeRegM == rsD || writeRegM == rtD);

    assign lwStall     = memToRegE && hitE;
    assign branchStall = branchD && ((regWriteE && hitE) || (memToRegM && hitM));
    assign mulStall    = mulStartE && !mulReadyE;

    assign stallF = lwStall || branchStall || mulStall;
    assign stallD = stallF;
    assign stallE = mulStall;  // Only the multiplier holds execute
    assign flushD = (pcSrcD || jumpD) && !stallD;
    assign flushE = lwStall || branchStall;

    // Redirect must never squash an instruction that decode is holding
    assert property (@(posedge clk) !(flushD && stallD));

endmodule

`default_nettype wire

// File: src/datapath.sv
`timescale 1ns/1ns
`default_nettype none

module datapath import mipsPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  word_t      instr,
    input  word_t      dataRdata,
    input  logic       branchD,
    input  logic       jumpD,
    input  aluOp_t     aluOpE,
    input  logic       aluSrcE,
    input  logic       regDstE,
    input  logic       hiloWriteE,
    input  logic       hiloToRegE,
    input  logic       mulStartE,
    input  logic       retSrcM,
    input  logic       regWriteW,
    input  logic       memToRegW,
    input  logic       stallF,
    input  logic       stallD,
    input  logic       stallE,
    input  logic       flushD,
    input  logic       flushE,
    input  logic       forwardAD,
    input  logic       forwardBD,
    input  logic [1:0] forwardAE,
    input  logic [1:0] forwardBE,
    output word_t      instrAddr,
    output opcode_t    op,
    output funct_t     funct,
    output regAddr_t   rsD,
    output regAddr_t   rtD,
    output regAddr_t   rsE,
    output regAddr_t   rtE,
    output regAddr_t   writeRegE,
    output regAddr_t   writeRegM,
    output regAddr_t   writeRegW,
    output logic       pcSrcD,
    output logic       mulReadyE,
    output word_t      dataAddr,
    output word_t      dataWdata
);

    word_t       pcF, pcNextF, pcPlus4F;
    word_t       instrD, pcPlus4D, immD, rd1D, rd2D, cmpAD, cmpBD;
    regAddr_t    rdD, rdE;
    logic [4:0]  shamtD, shamtE;
    word_t       rd1E, rd2E, immE, srcAE, srcBE, writeDataE, aluOutE, hiloE;
    word_t       hi, lo;
    logic [63:0] productE;
    word_t       aluOutM, writeDataM, hiloM, resultM;
    word_t       readDataW, resultW, wbDataW;

    function automatic word_t fwdPick(input logic [1:0] sel, input word_t regVal,
                                      input word_t memVal, input word_t wbVal);
        case (sel)
            FWD_MEM: return memVal;
            FWD_WB:  return wbVal;
            default: return regVal;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    assign instrAddr = pcF;
    assign pcPlus4F  = pcF + 32'd4;
    assign pcNextF   = jumpD  ? {pcPlus4D[31:28], instrD[25:0], 2'b00} :
                       pcSrcD ? pcPlus4D + {immD[29:0], 2'b00} : pcPlus4F;

    always_ff @(posedge clk) begin
        if (rst) begin
            pcF <= '0;
        end else if (!stallF) begin
            pcF <= pcNextF;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flushD) begin
            instrD   <= '0;  // All-zero word decodes as nop
            pcPlus4D <= '0;
        end else if (!stallD) begin
            instrD   <= instr;
            pcPlus4D <= pcPlus4F;
        end
    end

    //////////////////////////////////////////////////////////////////////
    assign op     = instrD[31:26];
    assign funct  = instrD[5:0];
    assign rsD    = instrD[25:21];
    assign rtD    = instrD[20:16];
    assign rdD    = instrD[15:11];
    assign shamtD = instrD[10:6];
    assign immD   = (op == OP_ORI) ? {16'b0, instrD[15:0]} : {{16{instrD[15]}}, instrD[15:0]};

    regFile regFileInst (
        .clk (clk),
        .rst (rst),
        .we  (regWriteW),
        .ra1 (rsD),
        .ra2 (rtD),
        .wa  (writeRegW),
        .wd  (wbDataW),
        .rd1 (rd1D),
        .rd2 (rd2D)
    );

    assign cmpAD  = forwardAD ? resultM : rd1D;
    assign cmpBD  = forwardBD ? resultM : rd2D;
    assign pcSrcD = branchD && (cmpAD == cmpBD);  // beq resolved in decode

    always_ff @(posedge clk) begin
        if (rst || (flushE && !stallE)) begin
            {rsE, rtE, rdE, shamtE, immE, rd1E, rd2E} <= '0;
        end else if (!stallE) begin
            {rsE, rtE, rdE, shamtE, immE, rd1E, rd2E} <=
                {rsD, rtD, rdD, shamtD, immD, rd1D, rd2D};
        end
    end

    //////////////////////////////////////////////////////////////////////
    assign srcAE      = fwdPick(forwardAE, rd1E, resultM, wbDataW);
    assign writeDataE = fwdPick(forwardBE, rd2E, resultM, wbDataW);
    assign srcBE      = aluSrcE ? immE : writeDataE;
    assign writeRegE  = regDstE ? rdE : rtE;

    alu aluInst (
        .aluOp  (aluOpE),
        .srcA   (srcAE),
        .srcB   (srcBE),
        .shamt  (shamtE),
        .result (aluOutE)
    );

    multiplyUnit multiplyUnitInst (
        .clk     (clk),
        .rst     (rst),
        .start   (mulStartE),
        .srcA    (srcAE),
        .srcB    (writeDataE),  // rt operand, never the immediate
        .product (productE),
        .ready   (mulReadyE)
    );

    always_ff @(posedge clk) begin
        if (hiloWriteE && mulReadyE) begin
            {hi, lo} <= productE;
        end
    end

    assign hiloE = hiloToRegE ? hi : lo;

    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        aluOutM    <= aluOutE;
        writeDataM <= writeDataE;
        writeRegM  <= writeRegE;
        hiloM      <= hiloE;
        readDataW  <= dataRdata;
        resultW    <= resultM;
        writeRegW  <= writeRegM;
    end

    assign resultM   = retSrcM ? hiloM : aluOutM;  // mfhi and mflo take HI/LO
    assign dataAddr  = aluOutM;
    assign dataWdata = writeDataM;
    assign wbDataW   = memToRegW ? readDataW : resultW;

    // Branch and jump targets keep fetch on word boundaries
    assert property (@(posedge clk) disable iff (rst) pcF[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: src/mipsCore.sv
`timescale 1ns/1ns
`default_nettype none

module mipsCore import mipsPkg::*; (
    input  logic  clk,
    input  logic  rst,
    output word_t instrAddr,
    input  word_t instr,
    output word_t dataAddr,
    output word_t dataWdata,
    output logic  dataWe,
    input  word_t dataRdata
);

    opcode_t    op;
    funct_t     funct;
    aluOp_t     aluOpE;
    logic       branchD, jumpD, pcSrcD;
    logic       aluSrcE, regDstE, hiloWriteE, hiloToRegE;
    logic       mulStartE, mulReadyE;
    logic       regWriteE, memToRegE, regWriteM, memToRegM, retSrcM;
    logic       regWriteW, memToRegW;
    regAddr_t   rsD, rtD, rsE, rtE;
    regAddr_t   writeRegE, writeRegM, writeRegW;
    logic       stallF, stallD, stallE, flushD, flushE;
    logic       forwardAD, forwardBD;
    logic [1:0] forwardAE, forwardBE;

    controller controllerInst (
        .*,
        .memWriteM(dataWe)  // Store strobe leaves the core from memory stage
    );

    hazardUnit hazardUnitInst (.*);

    datapath datapathInst (.*);

endmodule

`default_nettype wire

// File: verification/mipsCore_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mipsCore_tb import mipsPkg::*; ();

    localparam int NUM_TESTS  = 10;
    localparam int PROG_LEN   = 12;
    localparam int MEM_WORDS  = 64;
    localparam int TEST_LIMIT = 60;               // Cycles from reset release to the store
    localparam int RUN_LIMIT  = NUM_TESTS * 80;

    logic  clk;
    logic  rst;
    word_t instrAddr, instr, dataAddr, dataWdata, dataRdata;
    logic  dataWe;

    word_t imem [MEM_WORDS];
    word_t dmem [MEM_WORDS];

    string testName  [NUM_TESTS];
    word_t progTable [NUM_TESTS][PROG_LEN];
    word_t expAddr   [NUM_TESTS];
    word_t expData   [NUM_TESTS];

    word_t lcgState    = 32'd67147;
    int    passCount   = 0;
    int    failCount   = 0;
    int    totalCycles = 0;

    mipsCore mipsCore_inst (
        .clk       (clk),
        .rst       (rst),
        .instrAddr (instrAddr),
        .instr     (instr),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .dataWe    (dataWe),
        .dataRdata (dataRdata)
    );

    //////////////////////////////////////////////////////////////////////
    assign instr     = imem[instrAddr[7:2]];  // Word addressed
    assign dataRdata = dmem[dataAddr[7:2]];

    always @(posedge clk) begin
        if (dataWe) begin
            dmem[dataAddr[7:2]] <= dataWdata;
        end
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        totalCycles++;
        if (totalCycles >= RUN_LIMIT) begin
            $display("Run stopped after %0d cycles without finishing", totalCycles);
            $display("Test FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    function automatic word_t nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    function automatic word_t fillWord(input int idx);
        return 32'h5A00_0000 ^ (word_t'(idx) * 32'h0101_0107);  // Differs for every word
    endfunction

    function automatic word_t encR(input regAddr_t rs, input regAddr_t rt, input regAddr_t rd,
                                   input logic [4:0] sh, input funct_t fn);
        return {OP_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t encI(input opcode_t opc, input regAddr_t rs, input regAddr_t rt,
                                   input logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    function automatic word_t sext16(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    // Full 32-bit constant from ori, sll 16, ori
    task automatic putConst(input int t, input int pos, input regAddr_t r, input word_t v);
        progTable[t][pos]     = encI(OP_ORI, 5'd0, r, v[31:16]);
        progTable[t][pos + 1] = encR(5'd0, r, r, 5'd16, FN_SLL);
        progTable[t][pos + 2] = encI(OP_ORI, r, r, v[15:0]);
    endtask

    task automatic setEntry(input int t, input string name, input word_t addr,
                            input word_t value);
        testName[t] = name;
        expAddr[t]  = addr;
        expData[t]  = value;
    endtask

    task automatic multProgram(input int t, input word_t a, input word_t b,
                               input regAddr_t storeReg, input logic [15:0] addr);
        putConst(t, 0, 5'd1, a);
        putConst(t, 3, 5'd2, b);
        progTable[t][6] = encR(5'd1, 5'd2, 5'd0, 5'd0, FN_MULT);
        progTable[t][7] = encR(5'd0, 5'd0, 5'd3, 5'd0, FN_MFHI);
        progTable[t][8] = encR(5'd0, 5'd0, 5'd4, 5'd0, FN_MFLO);
        progTable[t][9] = encI(OP_SW, 5'd0, storeReg, addr);
    endtask

    //////////////////////////////////////////////////////////////////////
    task automatic buildTable();
        word_t              a, b, c, d, e;
        logic [15:0]        i1, i2;
        logic signed [63:0] opA, opB, prod;
        for (int t = 0; t < NUM_TESTS; t++) begin
            for (int k = 0; k < PROG_LEN; k++) begin
                progTable[t][k] = '0;  // nop
            end
        end

        // Chain add, sub, and with M and W forwarding
        a = nextRand();
        b = nextRand();
        putConst(0, 0, 5'd1, a);
        putConst(0, 3, 5'd2, b);
        progTable[0][6] = encR(5'd1, 5'd2, 5'd3, 5'd0, FN_ADD);
        progTable[0][7] = encR(5'd3, 5'd2, 5'd4, 5'd0, FN_SUB);
        progTable[0][8] = encR(5'd4, 5'd3, 5'd5, 5'd0, FN_AND);
        progTable[0][9] = encI(OP_SW, 5'd0, 5'd5, 16'd8);
        c = a + b;
        setEntry(0, "fwd_add_sub_and", 32'd8, (c - b) & c);

        a = nextRand();
        b = nextRand();
        putConst(1, 0, 5'd1, a);
        putConst(1, 3, 5'd2, b);
        progTable[1][6]  = encR(5'd1, 5'd2, 5'd3, 5'd0, FN_OR);
        progTable[1][7]  = encR(5'd0, 5'd3, 5'd4, 5'd7, FN_SLL);
        progTable[1][8]  = encR(5'd4, 5'd3, 5'd5, 5'd0, FN_SLT);
        progTable[1][9]  = encR(5'd5, 5'd4, 5'd6, 5'd0, FN_OR);
        progTable[1][10] = encI(OP_SW, 5'd0, 5'd6, 16'd12);
        c = a | b;
        d = c << 7;
        e = ($signed(d) < $signed(c)) ? 32'd1 : 32'd0;
        setEntry(1, "fwd_or_slt_sll", 32'd12, e | d);

        i1 = 16'(nextRand() >> 16);
        progTable[2][0] = encI(OP_LW, 5'd0, 5'd2, 16'd24);
        progTable[2][1] = encI(OP_ADDI, 5'd2, 5'd3, i1);  // Load-use
        progTable[2][2] = encI(OP_SW, 5'd0, 5'd3, 16'd28);
        setEntry(2, "load_use", 32'd28, fillWord(6) + sext16(i1));

        a = nextRand();
        progTable[3][0] = encI(OP_ADDI, 5'd0, 5'd3, 16'd7);
        putConst(3, 1, 5'd1, a);
        progTable[3][4] = encR(5'd1, 5'd0, 5'd2, 5'd0, FN_OR);
        progTable[3][5] = encI(OP_BEQ, 5'd1, 5'd2, 16'd1);
        progTable[3][6] = encI(OP_ADDI, 5'd3, 5'd3, 16'd100);  // Flushed
        progTable[3][7] = encI(OP_SW, 5'd0, 5'd3, 16'd16);
        setEntry(3, "beq_taken", 32'd16, 32'd7);

        a = nextRand();
        progTable[4][0] = encI(OP_ADDI, 5'd0, 5'd3, 16'd7);
        putConst(4, 1, 5'd1, a);
        progTable[4][4] = encI(OP_ADDI, 5'd1, 5'd2, 16'd1);
        progTable[4][5] = encI(OP_BEQ, 5'd1, 5'd2, 16'd1);
        progTable[4][6] = encI(OP_ADDI, 5'd3, 5'd3, 16'd100);
        progTable[4][7] = encI(OP_SW, 5'd0, 5'd3, 16'd20);
        setEntry(4, "beq_not_taken", 32'd20, 32'd107);

        progTable[5][0] = encI(OP_ADDI, 5'd0, 5'd4, 16'd1);
        progTable[5][1] = {OP_J, 26'd4};
        progTable[5][2] = encI(OP_ADDI, 5'd4, 5'd4, 16'd50);
        progTable[5][3] = encI(OP_ADDI, 5'd4, 5'd4, 16'd60);
        progTable[5][4] = encI(OP_ADDI, 5'd4, 5'd4, 16'd2);
        progTable[5][5] = encI(OP_SW, 5'd0, 5'd4, 16'd40);
        setEntry(5, "jump_skip", 32'd40, 32'd3);

        // Signed 64-bit product split into HI and LO
        a = nextRand();
        b = nextRand();
        opA = $signed(a);
        opB = $signed(b);
        prod = opA * opB;
        multProgram(6, a, b, 5'd3, 16'd44);
        setEntry(6, "mult_hi", 32'd44, prod[63:32]);

        a = nextRand();
        b = nextRand();
        opA = $signed(a);
        opB = $signed(b);
        prod = opA * opB;
        multProgram(7, a, b, 5'd4, 16'd48);
        setEntry(7, "mult_lo", 32'd48, prod[31:0]);

        i1 = 16'(nextRand() >> 16) | 16'h8000;  // Top bit set on purpose
        i2 = 16'(nextRand() >> 16) | 16'h8000;
        progTable[8][0] = encI(OP_ORI, 5'd0, 5'd5, i1);
        progTable[8][1] = encI(OP_ORI, 5'd5, 5'd5, i2);
        progTable[8][2] = encI(OP_SW, 5'd0, 5'd5, 16'd52);
        setEntry(8, "ori_zero_ext", 32'd52, {16'b0, i1 | i2});

        i1 = 16'(nextRand() >> 16) | 16'h8000;
        i2 = 16'(nextRand() >> 16) | 16'h8000;
        progTable[9][0] = encI(OP_ADDI, 5'd0, 5'd6, i1);
        progTable[9][1] = encI(OP_ADDI, 5'd6, 5'd6, i2);
        progTable[9][2] = encI(OP_SW, 5'd0, 5'd6, 16'd56);
        setEntry(9, "addi_sign_ext", 32'd56, sext16(i1) + sext16(i2));
    endtask

    //////////////////////////////////////////////////////////////////////
    task automatic runTest(input int t);
        int cyc;
        bit stored;
        bit ok;
        ok     = 1'b1;
        stored = 1'b0;
        cyc    = 0;

        @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);  // First reset edge
        @(negedge clk);
        assert (!dataWe) else begin
            $display("%s: store strobe was high during reset", testName[t]);
            ok = 1'b0;
        end
        assert (instrAddr == 32'h0) else begin
            $display("[ERROR] %s: fetch address in reset expected %h, actual %h",
                     testName[t], 32'h0, instrAddr);
            ok = 1'b0;
        end
        for (int k = 0; k < MEM_WORDS; k++) begin
            imem[k] = (k < PROG_LEN) ? progTable[t][k] : '0;
            dmem[k] = fillWord(k);
        end
        @(posedge clk);  // Second reset edge
        rst <= 1'b0;

        while (!stored && cyc < TEST_LIMIT) begin
            @(negedge clk);
            cyc++;
            if (cyc <= 4) begin
                assert (!dataWe) else begin
                    $display("%s: store strobe went high %0d cycles after reset",
                             testName[t], cyc);
                    ok = 1'b0;
                end
            end
            stored = dataWe;  // Store lands on the next rising edge
        end

        assert (stored) else begin
            $display("%s: no store occurred within %0d cycles", testName[t], TEST_LIMIT);
            ok = 1'b0;
        end
        if (stored) begin
            assert (dataAddr == expAddr[t]) else begin
                $display("[ERROR] %s: store address expected %h, actual %h",
                         testName[t], expAddr[t], dataAddr);
                ok = 1'b0;
            end
            assert (dataWdata == expData[t]) else begin
                $display("[ERROR] %s: store data expected %h, actual %h",
                         testName[t], expData[t], dataWdata);
                ok = 1'b0;
            end
        end

        $display("%s %s", testName[t], ok ? "passed" : "failed");
        if (ok) begin
            passCount++;
        end else begin
            failCount++;
        end
    endtask

    initial begin
        rst = 1'b1;
        for (int k = 0; k < MEM_WORDS; k++) begin
            imem[k] = '0;
            dmem[k] = fillWord(k);
        end
        buildTable();
        for (int t = 0; t < NUM_TESTS; t++) begin
            runTest(t);
        end
        $display("%0d tests passed, %0d failed", passCount, failCount);
        if (failCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
src/mipsPkg.sv
src/regFile.sv
src/alu.sv
src/multiplyUnit.sv
src/controller.sv
src/hazardUnit.sv
src/datapath.sv
src/mipsCore.sv
verification/mipsCore_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mipsCore_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
